//--- build.f
+incdir+common
common/cpu_pkg.sv
common/stage_if.sv
hazard/hazard_ctrl.sv
hazard/fwd_unit.sv
design/stage_track.sv
design/muldiv_timer.sv
design/hazard_top.sv
tests/tb_hazard_top.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; pass only if the pass message appears.
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_hazard_top -Mdir obj_dir \
    && ./obj_dir/Vtb_hazard_top | tee /dev/stderr | grep -q "All tests passed" \
    && exit 0 \
    || exit 1

//--- tests/tb_hazard_top.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tb_hazard_top;
    import cpu_pkg::*;

    typedef struct {
        string       name;
        instr_desc_t d;
        logic [2:0]  env;     // imem_busy, dmem_busy, bfrome.
        stage_vec_t  st;
        stage_vec_t  fl;
        fwd_sel_t    fda;
        fwd_sel_t    fdb;
        fwd_sel_t    fea;
        fwd_sel_t    feb;
        fwd_sel_t    hi;
        fwd_sel_t    lo;
        logic        g;
    } row_t;

    localparam stage_vec_t V_NONE = 5'b00000;
    localparam stage_vec_t V_ALL  = 5'b11111;
    localparam stage_vec_t V_FD   = 5'b11000;
    localparam stage_vec_t V_E    = 5'b00100;
    localparam stage_vec_t V_D    = 5'b01000;
    localparam stage_vec_t V_FDEM = 5'b11110;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    instr_desc_t d_in = '0;
    logic imem_busy = 1'b0;
    logic dmem_busy = 1'b0;
    logic bfrome = 1'b0;
    stage_vec_t stall;
    stage_vec_t flush;
    fwd_sel_t fwd_d_a;
    fwd_sel_t fwd_d_b;
    fwd_sel_t fwd_e_a;
    fwd_sel_t fwd_e_b;
    fwd_sel_t hi_fwd_d;
    fwd_sel_t lo_fwd_d;
    logic guess_taken;
    row_t rows[$];

    always #5 clk = ~clk;

    hazard_top DUT (
        .clk (clk), .rst_n (rst_n),
        .d_valid (d_in.valid), .d_rs (d_in.rs), .d_rt (d_in.rt),
        .d_reg_waddr (d_in.reg_waddr), .d_regwrite (d_in.regwrite),
        .d_memtoreg (d_in.memtoreg), .d_isbranch (d_in.isbranch),
        .d_jr (d_in.jr), .d_link (d_in.link), .d_out_sel (d_in.out_sel),
        .d_hi_wen (d_in.hi_wen), .d_lo_wen (d_in.lo_wen), .d_md_op (d_in.md_op),
        .d_exc (d_in.exc), .d_eret (d_in.eret),
        .imem_busy (imem_busy), .dmem_busy (dmem_busy), .bfrome (bfrome),
        .stall (stall), .flush (flush),
        .fwd_d_a (fwd_d_a), .fwd_d_b (fwd_d_b), .fwd_e_a (fwd_e_a), .fwd_e_b (fwd_e_b),
        .hi_fwd_d (hi_fwd_d), .lo_fwd_d (lo_fwd_d), .guess_taken (guess_taken)
    );

    function automatic instr_desc_t alu(input int rs, input int rt, input int rd);
        instr_desc_t x;
        x = '0;
        x.valid = 1'b1;
        x.rs = `REG_W'(rs);
        x.rt = `REG_W'(rt);
        x.reg_waddr = `REG_W'(rd);
        x.regwrite = 1'b1;
        return x;
    endfunction

    function automatic instr_desc_t lw(input int rs, input int rt);
        instr_desc_t x;
        x = alu(rs, rt, rt);
        x.memtoreg = 1'b1;
        x.out_sel = OUT_MEM;
        return x;
    endfunction

    // Filler registers stay in r16..r23, clear of every tested register.
    function automatic instr_desc_t filler();
        instr_desc_t x;
        x = '0;
        x.valid = 1'b1;
        x.rs = `REG_W'(16 + $urandom % 8);
        x.rt = `REG_W'(16 + $urandom % 8);
        return x;
    endfunction

    function automatic instr_desc_t md(input md_op_t op);
        instr_desc_t x;
        x = '0;
        x.valid = 1'b1;
        x.md_op = op;
        x.hi_wen = 1'b1;
        x.lo_wen = 1'b1;
        return x;
    endfunction

    function automatic instr_desc_t mfhl(input out_sel_t src, input int rd);
        instr_desc_t x;
        x = alu(0, 0, rd);
        x.out_sel = src;
        return x;
    endfunction

    function automatic instr_desc_t branch(input int rs, input logic is_jr);
        instr_desc_t x;
        x = '0;
        x.valid = 1'b1;
        x.rs = `REG_W'(rs);
        x.isbranch = !is_jr;
        x.jr = is_jr;
        return x;
    endfunction

    function automatic instr_desc_t special(input logic link, input logic exc,
                                            input logic eret);
        instr_desc_t x;
        x = '0;
        x.valid = 1'b1;
        x.link = link;
        x.regwrite = link;
        x.reg_waddr = link ? `REG_W'(31) : '0;
        x.exc = exc;
        x.eret = eret;
        return x;
    endfunction

    task automatic add_row(input string name, input instr_desc_t d, input logic [2:0] env,
                           input stage_vec_t st, input stage_vec_t fl);
        row_t r;
        r.name = name;
        r.d = d;
        r.env = env;
        r.st = st;
        r.fl = fl;
        r.fda = FWD_NONE;
        r.fdb = FWD_NONE;
        r.fea = FWD_NONE;
        r.feb = FWD_NONE;
        r.hi = FWD_NONE;
        r.lo = FWD_NONE;
        r.g = 1'b0;
        rows.push_back(r);
    endtask

    task automatic set_fwd(input fwd_sel_t a, input fwd_sel_t b, input fwd_sel_t c,
                           input fwd_sel_t e);
        rows[rows.size()-1].fda = a;
        rows[rows.size()-1].fdb = b;
        rows[rows.size()-1].fea = c;
        rows[rows.size()-1].feb = e;
    endtask

    task automatic set_hilo(input fwd_sel_t hi, input fwd_sel_t lo);
        rows[rows.size()-1].hi = hi;
        rows[rows.size()-1].lo = lo;
    endtask

    task automatic check_vec(input string name, input string what, input stage_vec_t exp,
                             input stage_vec_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
            $display("Some tests failed");
            $fatal(1, "Wrong stage vector.");
        end
    endtask

    task automatic check_fwd(input string name, input string what, input fwd_sel_t exp,
                             input fwd_sel_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s %s: expected %s, actual %s", name, what,
                     exp.name(), act.name());
            $display("Some tests failed");
            $fatal(1, "Wrong forwarding select.");
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
            $display("Some tests failed");
            $fatal(1, "Wrong flag.");
        end
    endtask

    task automatic build_table();
        instr_desc_t held;
        add_row("lw_issue", lw(0, 2), 3'b000, V_NONE, V_NONE);
        add_row("lw_use_stall", alu(2, 0, 3), 3'b000, V_FD, V_E);
        add_row("lw_fwd_m", alu(2, 0, 3), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_M, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("lw_fwd_w", alu(0, 2, 0), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_NONE, FWD_W, FWD_W, FWD_NONE);
        add_row("r0_write", alu(3, 0, 3), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_M, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("r0_in_m", alu(0, 3, 6), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_NONE, FWD_W, FWD_W, FWD_NONE);
        add_row("e_rt_fwd_m", filler(), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_NONE, FWD_NONE, FWD_NONE, FWD_M);
        repeat (2) add_row("drain", filler(), 3'b000, V_NONE, V_NONE);
        add_row("mul_issue", md(MD_MUL), 3'b000, V_NONE, V_NONE);
        repeat (`MUL_CYCLES) add_row("mul_busy", mfhl(OUT_HI, 7), 3'b000, V_ALL, V_NONE);
        add_row("mul_done", mfhl(OUT_HI, 7), 3'b000, V_FD, V_E);
        add_row("hi_fwd_m", mfhl(OUT_HI, 7), 3'b000, V_NONE, V_NONE);
        set_hilo(FWD_M, FWD_NONE);
        add_row("hi_fwd_w", mfhl(OUT_HI, 8), 3'b000, V_NONE, V_NONE);
        set_hilo(FWD_W, FWD_NONE);
        add_row("div_issue", md(MD_DIV), 3'b000, V_NONE, V_NONE);
        repeat (`DIV_CYCLES) add_row("div_busy", mfhl(OUT_LO, 9), 3'b000, V_ALL, V_NONE);
        add_row("div_done", mfhl(OUT_LO, 9), 3'b000, V_FD, V_E);
        add_row("lo_fwd_m", mfhl(OUT_LO, 9), 3'b000, V_NONE, V_NONE);
        set_hilo(FWD_NONE, FWD_M);
        add_row("lo_fwd_w", mfhl(OUT_LO, 10), 3'b000, V_NONE, V_NONE);
        set_hilo(FWD_NONE, FWD_W);
        repeat (2) add_row("drain", filler(), 3'b000, V_NONE, V_NONE);
        add_row("lw2_issue", lw(0, 11), 3'b000, V_NONE, V_NONE);
        add_row("dmem_override", alu(11, 0, 12), 3'b011, V_ALL, V_NONE);
        add_row("lw2_stall", alu(11, 0, 12), 3'b000, V_FD, V_E);
        add_row("imem_only", alu(11, 0, 12), 3'b100, V_FD, V_E);
        set_fwd(FWD_M, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("after_imem", alu(11, 0, 12), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_W, FWD_NONE, FWD_NONE, FWD_NONE);
        held = filler();
        add_row("imem_bfrome", held, 3'b101, V_ALL, V_NONE);
        add_row("bfrome_only", held, 3'b001, V_NONE, V_D);
        add_row("exc_issue", special(1'b0, 1'b1, 1'b0), 3'b000, V_NONE, V_NONE);
        add_row("exc_in_e", filler(), 3'b000, V_NONE, V_NONE);
        held = filler();
        add_row("exc_m_imem", held, 3'b100, V_ALL, V_NONE);
        add_row("exc_in_m", held, 3'b000, V_NONE, V_FDEM);
        add_row("eret_issue", special(1'b0, 1'b0, 1'b1), 3'b000, V_NONE, V_NONE);
        add_row("eret_in_e", filler(), 3'b000, V_NONE, V_NONE);
        add_row("eret_in_m", filler(), 3'b000, V_NONE, V_FDEM);
        add_row("alu_w13", alu(0, 0, 13), 3'b000, V_NONE, V_NONE);
        add_row("branch_guess", branch(13, 1'b0), 3'b000, V_NONE, V_NONE);
        rows[rows.size()-1].g = 1'b1;
        add_row("branch_fwd", branch(13, 1'b0), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_M, FWD_NONE, FWD_M, FWD_NONE);
        add_row("alu_w14", alu(0, 0, 14), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_NONE, FWD_NONE, FWD_W, FWD_NONE);
        add_row("jr_stall", branch(14, 1'b1), 3'b000, V_FD, V_E);
        add_row("jr_fwd", branch(14, 1'b1), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_M, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("jal_issue", special(1'b1, 1'b0, 1'b0), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_NONE, FWD_NONE, FWD_W, FWD_NONE);
        add_row("link_stall_e", alu(31, 0, 15), 3'b000, V_FD, V_E);
        add_row("link_stall_m", alu(31, 0, 15), 3'b000, V_FD, V_E);
        set_fwd(FWD_M, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("link_fwd_w", alu(31, 0, 15), 3'b000, V_NONE, V_NONE);
        set_fwd(FWD_W, FWD_NONE, FWD_NONE, FWD_NONE);
        add_row("drain", filler(), 3'b000, V_NONE, V_NONE);
    endtask

    task automatic check_row(input row_t r);
        check_vec(r.name, "stall", r.st, stall);
        check_vec(r.name, "flush", r.fl, flush);
        check_fwd(r.name, "fwd_d_a", r.fda, fwd_d_a);
        check_fwd(r.name, "fwd_d_b", r.fdb, fwd_d_b);
        check_fwd(r.name, "fwd_e_a", r.fea, fwd_e_a);
        check_fwd(r.name, "fwd_e_b", r.feb, fwd_e_b);
        check_fwd(r.name, "hi_fwd_d", r.hi, hi_fwd_d);
        check_fwd(r.name, "lo_fwd_d", r.lo, lo_fwd_d);
        check_bit(r.name, "guess_taken", r.g, guess_taken);
    endtask

    initial
    begin
        #1;
        #((rows.size() + 20) * 10);
        $display("Timeout: the table did not finish within the expected time.");
        $display("Some tests failed");
        $fatal(1, "Watchdog expired.");
    end

    initial
    begin
        void'($urandom(32'hce40_5c38));
        build_table();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (rows[i])
        begin
            @(posedge clk);
            #1;
            d_in = rows[i].d;
            {imem_busy, dmem_busy, bfrome} = rows[i].env;
            #8;                                 // Just before the next edge.
            check_row(rows[i]);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- design/hazard_top.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module hazard_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                d_valid,
    input  logic [`REG_W-1:0]   d_rs,
    input  logic [`REG_W-1:0]   d_rt,
    input  logic [`REG_W-1:0]   d_reg_waddr,
    input  logic                d_regwrite,
    input  logic                d_memtoreg,
    input  logic                d_isbranch,
    input  logic                d_jr,
    input  logic                d_link,
    input  cpu_pkg::out_sel_t   d_out_sel,
    input  logic                d_hi_wen,
    input  logic                d_lo_wen,
    input  cpu_pkg::md_op_t     d_md_op,
    input  logic                d_exc,
    input  logic                d_eret,
    input  logic                imem_busy,
    input  logic                dmem_busy,
    input  logic                bfrome,
    output cpu_pkg::stage_vec_t stall,
    output cpu_pkg::stage_vec_t flush,
    output cpu_pkg::fwd_sel_t   fwd_d_a,
    output cpu_pkg::fwd_sel_t   fwd_d_b,
    output cpu_pkg::fwd_sel_t   fwd_e_a,
    output cpu_pkg::fwd_sel_t   fwd_e_b,
    output cpu_pkg::fwd_sel_t   hi_fwd_d,
    output cpu_pkg::fwd_sel_t   lo_fwd_d,
    output logic                guess_taken
);
    import cpu_pkg::*;

    stage_if d_if ();
    stage_if e_if ();
    stage_if m_if ();
    stage_if w_if ();

    assign d_if.desc = '{
        valid:     d_valid,
        rs:        d_rs,
        rt:        d_rt,
        reg_waddr: d_reg_waddr,
        regwrite:  d_regwrite,
        memtoreg:  d_memtoreg,
        isbranch:  d_isbranch,
        jr:        d_jr,
        link:      d_link,
        out_sel:   d_out_sel,
        hi_wen:    d_hi_wen,
        lo_wen:    d_lo_wen,
        md_op:     d_md_op,
        exc:       d_exc,
        eret:      d_eret
    };

    stage_track u_stage_track (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (d_if.snk),
        .e     (e_if.src),
        .m     (m_if.src),
        .w     (w_if.src),
        .stall (stall),
        .flush (flush)
    );

    fwd_unit u_fwd_unit (
        .d           (d_if.snk),
        .e           (e_if.snk),
        .m           (m_if.snk),
        .w           (w_if.snk),
        .fwd_d_a     (fwd_d_a),
        .fwd_d_b     (fwd_d_b),
        .fwd_e_a     (fwd_e_a),
        .fwd_e_b     (fwd_e_b),
        .hi_fwd_d    (hi_fwd_d),
        .lo_fwd_d    (lo_fwd_d),
        .guess_taken (guess_taken)
    );

    hazard_ctrl u_hazard_ctrl (
        .d         (d_if.snk),
        .e         (e_if.snk),
        .m         (m_if.snk),
        .md_busy   (e_if.md_busy),
        .imem_busy (imem_busy),
        .dmem_busy (dmem_busy),
        .bfrome    (bfrome),
        .stall     (stall),
        .flush     (flush)
    );

    muldiv_timer u_muldiv_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .e       (e_if.snk),
        .md_busy (e_if.md_busy)
    );

endmodule

//--- design/muldiv_timer.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module muldiv_timer (
    input  logic clk,
    input  logic rst_n,
    stage_if.snk e,
    output logic md_busy
);
    import cpu_pkg::*;

    localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

    logic [CNT_W-1:0] lat;
    logic [CNT_W-1:0] left;   // Busy cycles still to come after this one.
    logic             run;    // Counter loaded for the op in E.
    logic             done;
    logic             active;
    logic             last;
    logic             e_change;

    always_comb
    begin
        case (e.desc.md_op)
            MD_MUL:  lat = CNT_W'(`MUL_CYCLES);
            MD_DIV:  lat = CNT_W'(`DIV_CYCLES);
            default: lat = '0;
        endcase
    end

    assign active   = e.desc.valid && e.desc.md_op != MD_NONE;
    assign md_busy  = active && !done;
    assign last     = run ? (left == CNT_W'(1)) : (lat == CNT_W'(1));
    assign e_change = e.flush || !e.stall; // E register reloads at this edge.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            left <= '0;
            run  <= 1'b0;
            done <= 1'b0;
        end
        else if (e_change)
        begin
            left <= '0;
            run  <= 1'b0;
            done <= 1'b0;
        end
        else if (md_busy)
        begin
            left <= run ? left - CNT_W'(1) : lat - CNT_W'(1);
            run  <= 1'b1;
            done <= last;
        end
    end

endmodule

//--- design/stage_track.sv
`timescale 1ns/10ps

module stage_track (
    input  logic                clk,
    input  logic                rst_n,
    stage_if.snk                d,
    stage_if.src                e,
    stage_if.src                m,
    stage_if.src                w,
    input  cpu_pkg::stage_vec_t stall,
    input  cpu_pkg::stage_vec_t flush
);
    import cpu_pkg::*;

    instr_desc_t e_q;
    instr_desc_t m_q;
    instr_desc_t w_q;

    // Flush beats stall, stall beats advance.
    function automatic instr_desc_t next_desc(input logic        fl,
                                              input logic        st,
                                              input instr_desc_t cur,
                                              input instr_desc_t prev);
        instr_desc_t nxt;
        if (fl)
            nxt = '0;
        else if (st)
            nxt = cur;
        else
            nxt = prev;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            e_q <= '0;
            m_q <= '0;
            w_q <= '0;
        end
        else
        begin
            e_q <= next_desc(flush.e, stall.e, e_q, d.desc);
            m_q <= next_desc(flush.m, stall.m, m_q, e_q);
            w_q <= next_desc(flush.w, stall.w, w_q, m_q);
        end
    end

    assign e.desc = e_q;
    assign m.desc = m_q;
    assign w.desc = w_q;

    // Per-stage levels for the blocks that watch a single stage.
    assign e.stall = stall.e;
    assign e.flush = flush.e;

endmodule

//--- hazard/fwd_unit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module fwd_unit (
    stage_if.snk               d,
    stage_if.snk               e,
    stage_if.snk               m,
    stage_if.snk               w,
    output cpu_pkg::fwd_sel_t  fwd_d_a,
    output cpu_pkg::fwd_sel_t  fwd_d_b,
    output cpu_pkg::fwd_sel_t  fwd_e_a,
    output cpu_pkg::fwd_sel_t  fwd_e_b,
    output cpu_pkg::fwd_sel_t  hi_fwd_d,
    output cpu_pkg::fwd_sel_t  lo_fwd_d,
    output logic               guess_taken
);
    import cpu_pkg::*;

    // M is younger than W, so it wins. r0 is never forwarded.
    function automatic fwd_sel_t gpr_sel(input logic [`REG_W-1:0] src,
                                         input instr_desc_t mw,
                                         input instr_desc_t ww);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (src != '0)
        begin
            if (mw.regwrite && mw.reg_waddr == src)
                sel = FWD_M;
            else if (ww.regwrite && ww.reg_waddr == src)
                sel = FWD_W;
        end
        return sel;
    endfunction

    function automatic fwd_sel_t hilo_sel(input logic reads, input logic m_wen,
                                          input logic w_wen);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (reads && m_wen)
            sel = FWD_M;
        else if (reads && w_wen)
            sel = FWD_W;
        return sel;
    endfunction

    logic e_hit;
    logic m_hit;

    assign fwd_d_a = gpr_sel(d.desc.rs, m.desc, w.desc);
    assign fwd_d_b = gpr_sel(d.desc.rt, m.desc, w.desc);
    assign fwd_e_a = gpr_sel(e.desc.rs, m.desc, w.desc);
    assign fwd_e_b = gpr_sel(e.desc.rt, m.desc, w.desc);

    assign hi_fwd_d = hilo_sel(d.desc.out_sel == OUT_HI, m.desc.hi_wen, w.desc.hi_wen);
    assign lo_fwd_d = hilo_sel(d.desc.out_sel == OUT_LO, m.desc.lo_wen, w.desc.lo_wen);

    // Branch operands not yet available in D.
    assign e_hit = e.desc.regwrite &&
                   (e.desc.reg_waddr == d.desc.rs || e.desc.reg_waddr == d.desc.rt);
    assign m_hit = m.desc.memtoreg &&
                   (m.desc.reg_waddr == d.desc.rs || m.desc.reg_waddr == d.desc.rt);

    assign guess_taken = d.desc.isbranch && (e_hit || m_hit);

endmodule

//--- hazard/hazard_ctrl.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module hazard_ctrl (
    stage_if.snk              d,
    stage_if.snk              e,
    stage_if.snk              m,
    input  logic              md_busy,
    input  logic              imem_busy,
    input  logic              dmem_busy,
    input  logic              bfrome,
    output cpu_pkg::stage_vec_t stall,
    output cpu_pkg::stage_vec_t flush
);
    import cpu_pkg::*;

    localparam stage_vec_t VEC_NONE = 5'b00000;
    localparam stage_vec_t VEC_ALL  = 5'b11111;
    localparam stage_vec_t VEC_FD   = 5'b11000;
    localparam stage_vec_t VEC_D    = 5'b01000;
    localparam stage_vec_t VEC_E    = 5'b00100;
    localparam stage_vec_t VEC_FDEM = 5'b11110;

    localparam logic [`REG_W-1:0] LINK_REG = `REG_W'(31);

    logic lw_stall;
    logic jr_stall;
    logic hilo_stall;
    logic link_stall;
    logic dep_stall;
    logic m_exc;

    // Load result is not ready until M.
    assign lw_stall = e.desc.memtoreg &&
                      (e.desc.rt == d.desc.rs || e.desc.rt == d.desc.rt);

    // The jump target is needed in D.
    assign jr_stall = d.desc.jr &&
                      ((e.desc.regwrite && e.desc.reg_waddr == d.desc.rs) ||
                       (m.desc.memtoreg && m.desc.reg_waddr == d.desc.rs));

    assign hilo_stall = (e.desc.hi_wen && d.desc.out_sel == OUT_HI) ||
                        (e.desc.lo_wen && d.desc.out_sel == OUT_LO);

    assign link_stall = (e.desc.link || m.desc.link) &&
                        (d.desc.rs == LINK_REG || d.desc.rt == LINK_REG);

    assign dep_stall = lw_stall || jr_stall || hilo_stall || link_stall;

    assign m_exc = m.desc.exc || m.desc.eret;

    // First match wins.
    always_comb
    begin
        stall = VEC_NONE;
        flush = VEC_NONE;
        if (dmem_busy)
        begin
            stall = VEC_ALL;
        end
        else if (imem_busy && m_exc)
        begin
            stall = VEC_ALL;             // Wait for the fetch before redirecting.
        end
        else if (m_exc)
        begin
            flush = VEC_FDEM;
        end
        else if (md_busy)
        begin
            stall = VEC_ALL;
        end
        else if (imem_busy && bfrome)
        begin
            stall = VEC_ALL;
        end
        else if (imem_busy)
        begin
            stall = VEC_FD;
            flush = VEC_E;
        end
        else if (bfrome)
        begin
            flush = VEC_D;               // Wrong-path instruction in D.
        end
        else if (dep_stall)
        begin
            stall = VEC_FD;
            flush = VEC_E;               // Bubble into E.
        end
    end

endmodule

//--- common/stage_if.sv
`timescale 1ns/10ps

interface stage_if;
    import cpu_pkg::*;

    instr_desc_t desc;
    logic        stall;   // This stage holds at the next edge.
    logic        flush;   // This stage loads a bubble at the next edge.
    logic        md_busy; // Multiply/divide still running in this stage.

    modport src (
        output desc,
        output stall,
        output flush
    );

    modport snk (
        input desc,
        input stall,
        input flush,
        input md_busy
    );

endinterface

//--- common/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // Register file.
        FWD_W    = 2'b01,
        FWD_M    = 2'b10
    } fwd_sel_t;

    typedef enum logic [1:0] {
        OUT_ALU = 2'b00,
        OUT_MEM = 2'b01,
        OUT_HI  = 2'b10,
        OUT_LO  = 2'b11
    } out_sel_t;

    typedef enum logic [1:0] {
        MD_NONE = 2'b00,
        MD_MUL  = 2'b01,
        MD_DIV  = 2'b10
    } md_op_t;

    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stage_vec_t;

    // One instruction as seen by the hazard logic; all zeros is a bubble.
    typedef struct packed {
        logic              valid;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] reg_waddr;
        logic              regwrite;
        logic              memtoreg;
        logic              isbranch;
        logic              jr;
        logic              link;      // Writes r31.
        out_sel_t          out_sel;
        logic              hi_wen;
        logic              lo_wen;
        md_op_t            md_op;
        logic              exc;
        logic              eret;
    } instr_desc_t;

endpackage

//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of a GPR index.
`define REG_W 5

// Busy time of the multi-cycle unit, in cycles spent in E.
`define MUL_CYCLES 4
`define DIV_CYCLES 12

`endif
